//--- sprite_defines.svh
`ifndef SPRITE_DEFINES_SVH
`define SPRITE_DEFINES_SVH

// screen geometry in pixels
`define SCREEN_W            320
`define SCREEN_HBLANK       80

// line timing, four cycles per pixel
`define LINE_CYCLE_PARAM    20
`define LINE_CYCLE_VISIBLE  (`LINE_CYCLE_PARAM + `SCREEN_W * 4)
`define LINE_CYCLE_MAX      (`LINE_CYCLE_PARAM + (`SCREEN_W + `SCREEN_HBLANK) * 4)

`define SPRITE_COUNT        128
`define PARAM_WORDS         2
`define HW_TILE             8

`define SP_IDX_W            7
`define PARAM_ADDR_W        8
`define TILE_ADDR_W         22
`define TILE_BANK_W         4
`define TILE_OFS_W          18
`define PAL_ADDR_W          10
`define PAL_BANK_W          2
`define LINE_ADDR_W         9
`define LINE_CYCLE_W        11

`endif

//--- sprite_pkg.sv
package sprite_pkg;

  // line phases of the sprite sequencer
  typedef enum logic [2:0] {
    ST_INIT,
    ST_FETCH,
    ST_DRAW,
    ST_IDLE,
    ST_WAIT
  } sp_state_t;

  // argb, alpha in the top byte
  typedef logic [31:0] color_t;

  // 0..3 map to edges of 8, 16, 32, 64
  typedef logic [1:0] tile_size_t;

  typedef logic [7:0] pal_idx_t;

  // sprite edge in pixels
  function automatic logic [6:0] tile_dim(input tile_size_t size);
    logic [6:0] dim;
    case (size)
      2'd0: dim = 7'd8;
      2'd1: dim = 7'd16;
      2'd2: dim = 7'd32;
      default: dim = 7'd64;
    endcase
    return dim;
  endfunction

endpackage

//--- sprite_sequencer.sv
`timescale 1ns/1ps
`include "sprite_defines.svh"

module sprite_sequencer
  import sprite_pkg::*;
(
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic [`LINE_CYCLE_W-1:0]  line_cycle,
  input  logic                      fetch_done,
  input  logic                      hit,
  input  logic                      draw_done,
  output logic                      line_init,
  output logic                      fetch_start,
  output logic                      draw_start,
  output logic [`SP_IDX_W-1:0]      sp_idx
);

  sp_state_t state;
  logic      sprite_end;
  logic      last_idx;

  // current sprite finished, either missed or fully drawn
  assign sprite_end = (state == ST_FETCH && fetch_done && !hit) ||
                      (state == ST_DRAW && draw_done);
  assign last_idx   = (sp_idx == `SP_IDX_W'(`SPRITE_COUNT - 1));

  assign line_init  = (state == ST_INIT);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state       <= ST_WAIT;
      sp_idx      <= '0;
      fetch_start <= 1'b0;
      draw_start  <= 1'b0;
    end else begin
      fetch_start <= 1'b0;
      draw_start  <= 1'b0;
      if (line_cycle < `LINE_CYCLE_PARAM) begin
        state  <= ST_INIT;
        sp_idx <= '0;
      end else if (line_cycle < `LINE_CYCLE_VISIBLE) begin
        if (state == ST_INIT) begin
          state       <= ST_FETCH;
          fetch_start <= 1'b1;
        end else if (state == ST_FETCH && fetch_done && hit) begin
          state      <= ST_DRAW;
          draw_start <= 1'b1;
        end else if (sprite_end) begin
          if (last_idx) begin
            state <= ST_IDLE;
          end else begin
            state       <= ST_FETCH;
            sp_idx      <= sp_idx + 1'b1;
            fetch_start <= 1'b1;
          end
        end
      end else begin
        // window closed, drop any remaining sprites
        state  <= ST_WAIT;
        sp_idx <= '0;
      end
    end
  end

endmodule

//--- sprite_attr_fetch.sv
`timescale 1ns/1ps
`include "sprite_defines.svh"

module sprite_attr_fetch
  import sprite_pkg::*;
(
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      fetch_start,
  input  logic [`SP_IDX_W-1:0]      sp_idx,
  input  logic [7:0]                y,
  input  logic [31:0]               param_data,
  output logic                      param_en,
  output logic [`PARAM_ADDR_W-1:0]  param_addr,
  output logic                      fetch_done,
  output logic                      hit,
  output logic [31:0]               word0,
  output logic [31:0]               word1
);

  logic       ph1;
  logic       ph2;
  logic       hit_now;
  logic [7:0] sy;
  logic [8:0] sy_end;

  // word 0 arrives on the bus in ph1
  assign sy      = param_data[7:0];
  assign sy_end  = {1'b0, sy} + 9'(tile_dim(tile_size_t'(param_data[25:24])));
  assign hit_now = param_data[31] && (y >= sy) && ({1'b0, y} < sy_end);

  // word 0 on the start cycle, word 1 right after a hit
  assign param_en   = fetch_start | (ph1 & hit_now);
  assign param_addr = `PARAM_ADDR_W'(sp_idx * `PARAM_WORDS) + `PARAM_ADDR_W'(ph1);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      ph1        <= 1'b0;
      ph2        <= 1'b0;
      fetch_done <= 1'b0;
      hit        <= 1'b0;
    end else begin
      ph1        <= fetch_start;
      ph2        <= ph1 & hit_now;
      fetch_done <= (ph1 & ~hit_now) | ph2;
      if (ph1) begin
        hit <= hit_now;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (ph1) begin
      word0 <= param_data;
    end
    if (ph2) begin
      word1 <= param_data;
    end
  end

endmodule

//--- sprite_pixel_pipe.sv
`timescale 1ns/1ps
`include "sprite_defines.svh"

module sprite_pixel_pipe
  import sprite_pkg::*;
(
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      draw_start,
  input  logic [7:0]                y,
  input  logic [31:0]               word0,
  input  logic [31:0]               word1,
  input  pal_idx_t                  tile_data,
  input  color_t                    pal_data,
  output logic                      tile_en,
  output logic [`TILE_ADDR_W-1:0]   tile_addr,
  output logic                      pal_en,
  output logic [`PAL_ADDR_W-1:0]    pal_addr,
  output logic                      draw_done,
  output logic                      px_valid,
  output logic [`LINE_ADDR_W-1:0]   px_x,
  output color_t                    px_color,
  output logic                      px_opaque_ok
);

  localparam int HW_BITS = $clog2(`HW_TILE);
  localparam int IDX_W   = `TILE_OFS_W - 2 * HW_BITS;

  // attribute fields
  logic [6:0]                 tw;
  logic [`LINE_ADDR_W-1:0]    sp_x;
  logic [7:0]                 sp_y;
  logic [`TILE_BANK_W-1:0]    tile_bank;
  logic [IDX_W-1:0]           tile_idx;
  logic                       pal_mode;
  logic [`PAL_BANK_W-1:0]     pal_bank;
  logic [3:0]                 pal_no;

  // stage 0, tile read
  logic                       active;
  logic [6:0]                 objx;
  logic [7:0]                 objy;
  logic                       last0;
  logic [`LINE_ADDR_W-1:0]    scr_x;
  logic [IDX_W-1:0]           tile_num;

  // stage 1, palette and line buffer read
  logic                       valid1;
  logic                       last1;
  logic [`LINE_ADDR_W-1:0]    x1;
  logic                       ok1;

  assign tw        = tile_dim(tile_size_t'(word0[25:24]));
  assign sp_x      = word0[16:8];
  assign sp_y      = word0[7:0];
  assign tile_bank = word1[31:28];
  assign tile_idx  = word1[27:16];
  assign pal_mode  = word1[6];
  assign pal_bank  = word1[5:4];
  assign pal_no    = word1[3:0];

  assign objy  = y - sp_y;
  assign last0 = active && (objx == tw - 7'd1);
  // wraps at 512
  assign scr_x = sp_x + `LINE_ADDR_W'(objx);

  // tiles are stored row major, 8x8 pixels each
  assign tile_num  = tile_idx + IDX_W'(objx / `HW_TILE) +
                     IDX_W'(objy / `HW_TILE) * IDX_W'(tw / `HW_TILE);
  assign tile_en   = active;
  assign tile_addr = {tile_bank, tile_num, HW_BITS'(objy % `HW_TILE),
                      HW_BITS'(objx % `HW_TILE)};

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      active <= 1'b0;
      objx   <= '0;
    end else if (draw_start) begin
      active <= 1'b1;
      objx   <= '0;
    end else if (active) begin
      if (last0) begin
        active <= 1'b0;
      end else begin
        objx <= objx + 7'd1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      valid1    <= 1'b0;
      last1     <= 1'b0;
      draw_done <= 1'b0;
    end else begin
      valid1    <= active;
      last1     <= last0;
      draw_done <= valid1 & last1;
    end
  end

  always_ff @(posedge clk) begin
    x1  <= scr_x;
    ok1 <= (scr_x < `SCREEN_W);
  end

  // 16-color mode picks a sub-palette by number
  assign pal_en   = valid1;
  assign pal_addr = pal_mode ? {pal_bank, pal_no, tile_data[3:0]} : {pal_bank, tile_data};

  assign px_valid     = valid1;
  assign px_x         = x1;
  assign px_opaque_ok = ok1;
  // arrives one cycle after px_valid
  assign px_color     = pal_data;

endmodule

//--- sprite_blend.sv
`timescale 1ns/1ps
`include "sprite_defines.svh"

module sprite_blend
  import sprite_pkg::*;
(
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic [7:0]                y,
  input  logic                      px_valid,
  input  logic [`LINE_ADDR_W-1:0]   px_x,
  input  logic                      px_opaque_ok,
  input  color_t                    px_color,
  input  color_t                    line_dout,
  output logic                      line_bank,
  output logic                      line_re,
  output logic [`LINE_ADDR_W-1:0]   line_raddr,
  output logic                      line_we,
  output logic [`LINE_ADDR_W-1:0]   line_waddr,
  output color_t                    line_din
);

  logic                     wr_valid;
  logic [`LINE_ADDR_W-1:0]  wr_addr;

  // src over dst with source alpha
  function automatic color_t blend_px(input color_t dst, input color_t src);
    color_t      res;
    logic [7:0]  a;
    logic [15:0] mix;
    logic [8:0]  asum;
    a   = src[31:24];
    res = dst;
    if (a == 8'hff) begin
      res = src;
    end else if (a != 8'h00) begin
      for (int i = 0; i < 3; i++) begin
        mix = dst[i*8 +: 8] * (8'd255 - a) + src[i*8 +: 8] * a;
        res[i*8 +: 8] = mix[15:8];
      end
      asum = dst[31:24] + a;
      res[31:24] = asum[8:1];
    end
    return res;
  endfunction

  // even lines in bank 0, odd in bank 1
  assign line_bank  = y[0];

  assign line_re    = px_valid & px_opaque_ok;
  assign line_raddr = px_x;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wr_valid <= 1'b0;
    end else begin
      wr_valid <= px_valid & px_opaque_ok;
    end
  end

  always_ff @(posedge clk) begin
    wr_addr <= px_x;
  end

  assign line_we    = wr_valid;
  assign line_waddr = wr_addr;
  assign line_din   = blend_px(line_dout, px_color);

endmodule

//--- sprite_engine.sv
`timescale 1ns/1ps
`include "sprite_defines.svh"

module sprite_engine
  import sprite_pkg::*;
(
  input  logic                        clk,
  input  logic                        rst_n,
  input  logic [`LINE_CYCLE_W-1:0]    line_cycle,
  input  logic [7:0]                  y,
  input  logic [31:0]                 param_data,
  input  pal_idx_t                    tile_data,
  input  color_t                      pal_data,
  input  color_t                      line_dout,
  output logic                        line_init,
  output logic                        param_en,
  output logic [`PARAM_ADDR_W-1:0]    param_addr,
  output logic                        tile_en,
  output logic [`TILE_ADDR_W-1:0]     tile_addr,
  output logic                        pal_en,
  output logic [`PAL_ADDR_W-1:0]      pal_addr,
  output logic                        line_bank,
  output logic                        line_re,
  output logic [`LINE_ADDR_W-1:0]     line_raddr,
  output logic                        line_we,
  output logic [`LINE_ADDR_W-1:0]     line_waddr,
  output color_t                      line_din
);

  // sequencer <-> attribute fetch
  logic                   fetch_start;
  logic                   fetch_done;
  logic                   hit;
  logic [`SP_IDX_W-1:0]   sp_idx;
  logic [31:0]            word0;
  logic [31:0]            word1;

  // sequencer <-> pixel pipe
  logic                   draw_start;
  logic                   draw_done;

  // pixel pipe -> blender
  logic                   px_valid;
  logic [`LINE_ADDR_W-1:0] px_x;
  color_t                 px_color;
  logic                   px_opaque_ok;

  sprite_sequencer u_seq (.*);

  sprite_attr_fetch u_fetch (.*);

  sprite_pixel_pipe u_pipe (.*);

  sprite_blend u_blend (.*);

endmodule

//--- tb_sprite_models.sv
`timescale 1ns/1ps
`include "sprite_defines.svh"

module tb_sprite_models
  import sprite_pkg::*;
(
  input  logic                      clk,
  input  logic                      line_init,
  input  logic                      param_en,
  input  logic [`PARAM_ADDR_W-1:0]  param_addr,
  input  logic                      tile_en,
  input  logic [`TILE_ADDR_W-1:0]   tile_addr,
  input  logic                      pal_en,
  input  logic [`PAL_ADDR_W-1:0]    pal_addr,
  input  logic                      line_bank,
  input  logic                      line_re,
  input  logic [`LINE_ADDR_W-1:0]   line_raddr,
  input  logic                      line_we,
  input  logic [`LINE_ADDR_W-1:0]   line_waddr,
  input  color_t                    line_din,
  output logic [31:0]               param_data,
  output pal_idx_t                  tile_data,
  output color_t                    pal_data,
  output color_t                    line_dout
);

  logic [31:0] sprite_tab [0:2*`SPRITE_COUNT-1];
  color_t      pal_mem [0:1023];
  // both line buffers indexed by {bank, x}
  color_t      line_mem [0:1023];
  color_t      ref_mem [0:1023];
  int          write_count = 0;

  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'hA300_0000) : (s >> 1);
  endfunction

  function automatic pal_idx_t tile_byte(input logic [`TILE_ADDR_W-1:0] addr);
    return 8'(addr * 37) >> 3;
  endfunction

  function automatic void put_sprite(input int idx, input int en, input int size, input int x,
                                     input int yy, input int tbank, input int tidx,
                                     input int mode, input int pbank, input int pno);
    sprite_tab[2*idx]   = {1'(en), 5'd0, 2'(size), 7'd0, 9'(x), 8'(yy)};
    sprite_tab[2*idx+1] = {4'(tbank), 12'(tidx), 9'd0, 1'(mode), 2'(pbank), 4'(pno)};
  endfunction

  // palette bank 0 is opaque, bank 1 fully transparent, 2 and 3 random alpha
  function automatic void load_set(input int set);
    for (int i = 0; i < 2*`SPRITE_COUNT; i++) begin
      sprite_tab[i] = '0;
    end
    if (set == 0) begin
      put_sprite(0, 0, 3, 0, 0, 1, 0, 0, 0, 0);
      put_sprite(1, 1, 0, 10, 4, 1, 5, 0, 0, 0);
      put_sprite(2, 1, 1, 40, 0, 2, 9, 1, 0, 3);
      put_sprite(3, 1, 2, 80, 0, 3, 100, 0, 2, 0);
      put_sprite(4, 1, 3, 200, 0, 4, 4000, 1, 0, 7);
      put_sprite(5, 1, 0, 100, 100, 0, 1, 0, 0, 0);
      // runs past the right edge
      put_sprite(6, 1, 3, 290, 30, 5, 7, 0, 3, 0);
      // wraps around to x 0..3
      put_sprite(7, 1, 1, 500, 0, 6, 2, 1, 2, 9);
    end else begin
      put_sprite(0, 1, 2, 60, 0, 1, 20, 0, 0, 0);
      put_sprite(1, 1, 1, 70, 0, 2, 3, 0, 2, 0);
      put_sprite(2, 1, 0, 72, 0, 3, 11, 1, 1, 5);
      put_sprite(3, 1, 3, 50, 2, 7, 50, 1, 3, 12);
      put_sprite(127, 1, 0, 300, 0, 8, 1, 0, 0, 0);
    end
  endfunction

  function automatic color_t blend_ref(input color_t dst, input color_t src);
    int     a;
    color_t res;
    a = int'(src[31:24]);
    if (a == 0)
      return dst;
    if (a == 255)
      return src;
    for (int k = 0; k < 3; k++) begin
      res[8*k +: 8] = 8'((int'(dst[8*k +: 8]) * (255 - a) + int'(src[8*k +: 8]) * a) / 256);
    end
    res[31:24] = 8'((int'(dst[31:24]) + a) / 2);
    return res;
  endfunction

  // expected buffer contents after one line
  function automatic void render_line(input logic [7:0] yv);
    logic [31:0]             w0;
    logic [31:0]             w1;
    int                      tw;
    int                      sy;
    int                      sx;
    int                      objy;
    int                      tnum;
    int                      paddr;
    logic [`TILE_ADDR_W-1:0] taddr;
    pal_idx_t                tdat;
    for (int i = 0; i < 512; i++) begin
      ref_mem[{yv[0], 9'(i)}] = '0;
    end
    for (int s = 0; s < `SPRITE_COUNT; s++) begin
      w0 = sprite_tab[2*s];
      w1 = sprite_tab[2*s+1];
      tw = 8 << w0[25:24];
      sy = int'(w0[7:0]);
      if (w0[31] && int'(yv) >= sy && int'(yv) < sy + tw) begin
        objy = int'(yv) - sy;
        for (int ox = 0; ox < tw; ox++) begin
          sx = (int'(w0[16:8]) + ox) % 512;
          if (sx < `SCREEN_W) begin
            tnum  = (int'(w1[27:16]) + ox / 8 + (objy / 8) * (tw / 8)) % 4096;
            taddr = {w1[31:28], 18'(tnum * 64 + (objy % 8) * 8 + ox % 8)};
            tdat  = tile_byte(taddr);
            if (w1[6])
              paddr = int'(w1[5:4]) * 256 + int'(w1[3:0]) * 16 + int'(tdat[3:0]);
            else
              paddr = int'(w1[5:4]) * 256 + int'(tdat);
            ref_mem[{yv[0], 9'(sx)}] = blend_ref(ref_mem[{yv[0], 9'(sx)}], pal_mem[paddr]);
          end
        end
      end
    end
  endfunction

  initial begin
    logic [31:0] lfsr;
    logic [31:0] word;
    lfsr = 32'd94908;
    for (int i = 0; i < 1024; i++) begin
      word = '0;
      for (int b = 0; b < 32; b++) begin
        word = {word[30:0], lfsr[0]};
        lfsr = lfsr_step(lfsr);
      end
      if (i < 256)
        word[31:24] = 8'hff;
      else if (i < 512)
        word[31:24] = 8'h00;
      pal_mem[i]  = word;
      line_mem[i] = '0;
      ref_mem[i]  = '0;
    end
    param_data <= '0;
    tile_data  <= '0;
    pal_data   <= '0;
    line_dout  <= '0;
  end

  always @(posedge clk) begin
    if (param_en)
      param_data <= sprite_tab[param_addr];
    if (tile_en)
      tile_data <= tile_byte(tile_addr);
    if (pal_en)
      pal_data <= pal_mem[pal_addr];
    if (line_re)
      line_dout <= line_mem[{line_bank, line_raddr}];
    // addressed bank wiped during line preparation
    if (line_init) begin
      for (int i = 0; i < 512; i++) begin
        line_mem[{line_bank, 9'(i)}] = '0;
      end
    end
    if (line_we) begin
      line_mem[{line_bank, line_waddr}] = line_din;
      write_count <= write_count + 1;
    end
  end

endmodule

//--- tb_sprite_engine.sv
`timescale 1ns/1ps
`include "sprite_defines.svh"

module tb_sprite_engine
  import sprite_pkg::*;
();

  localparam int ROWS  = 9;
  localparam int WD_NS = (ROWS * `LINE_CYCLE_MAX + 16 + 200) * 20;

  logic                       clk;
  logic                       rst_n;
  logic [`LINE_CYCLE_W-1:0]   line_cycle;
  logic [7:0]                 y;
  logic [31:0]                param_data;
  pal_idx_t                   tile_data;
  color_t                     pal_data;
  color_t                     line_dout;
  logic                       line_init;
  logic                       param_en;
  logic [`PARAM_ADDR_W-1:0]   param_addr;
  logic                       tile_en;
  logic [`TILE_ADDR_W-1:0]    tile_addr;
  logic                       pal_en;
  logic [`PAL_ADDR_W-1:0]     pal_addr;
  logic                       line_bank;
  logic                       line_re;
  logic [`LINE_ADDR_W-1:0]    line_raddr;
  logic                       line_we;
  logic [`LINE_ADDR_W-1:0]    line_waddr;
  color_t                     line_din;

  // per line: y, sprite set, pixels written
  int row_y   [ROWS] = '{0, 5, 6, 1, 20, 101, 12, 70, 200};
  int row_set [ROWS] = '{0, 0, 1, 1, 0, 0, 1, 0, 0};
  int row_cnt [ROWS] = '{116, 124, 128, 64, 96, 8, 112, 30, 0};

  int                         errors = 0;
  int                         checks = 0;
  int                         edges = 0;
  logic                       seen_rst = 1'b0;
  logic [`LINE_CYCLE_W-1:0]   seen_cycle = '0;

  sprite_engine dut0 (.*);

  tb_sprite_models mdl0 (.*);

  task automatic check_value(input string what, input logic [31:0] got,
                             input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("error at %0t: %s, got %h, expected %h", $time, what, got, exp);
    end
  endtask

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // what the DUT saw on the last edge
  always @(posedge clk) begin
    seen_cycle <= line_cycle;
    seen_rst   <= rst_n;
    edges      <= edges + 1;
  end

  always @(negedge clk) begin
    if (edges > 0 && !seen_rst) begin
      check_value("output active in reset",
                  32'({line_init, line_we, param_en, tile_en, pal_en, line_re}), '0);
    end else if (seen_rst) begin
      check_value("line_init phase", 32'(line_init),
                  32'(seen_cycle < `LINE_CYCLE_PARAM));
      if (line_init)
        check_value("memory access during line_init", 32'({tile_en, pal_en, line_we}), '0);
      if (line_we)
        check_value("write past screen edge", 32'(line_waddr >= `SCREEN_W), '0);
    end
  end

  initial begin
    int base;
    rst_n      = 1'b0;
    line_cycle = '0;
    y          = '0;
    repeat (16) @(posedge clk);
    rst_n <= 1'b1;
    for (int r = 0; r < ROWS; r++) begin
      mdl0.load_set(row_set[r]);
      mdl0.render_line(8'(row_y[r]));
      base = mdl0.write_count;
      for (int c = 0; c < `LINE_CYCLE_MAX; c++) begin
        @(posedge clk);
        line_cycle <= `LINE_CYCLE_W'(c);
        if (c == 0)
          y <= 8'(row_y[r]);
      end
      @(negedge clk);
      check_value($sformatf("pixels written on line y=%0d", row_y[r]),
                  32'(mdl0.write_count - base), 32'(row_cnt[r]));
      for (int i = 0; i < 1024; i++) begin
        check_value($sformatf("line y=%0d bank %0d x %0d", row_y[r], i / 512, i % 512),
                    mdl0.line_mem[i], mdl0.ref_mem[i]);
      end
    end
    $display("%0d checks, %0d errors", checks, errors);
    if (errors == 0)
      $display("TESTBENCH PASSED");
    else
      $display("TESTBENCH FAILED");
    $finish;
  end

  initial begin
    #(WD_NS);
    $display("timeout: the run did not finish within %0d ns", WD_NS);
    $display("TESTBENCH FAILED");
    $finish;
  end

endmodule

//--- compile.f
+incdir+.
sprite_pkg.sv
sprite_sequencer.sv
sprite_attr_fetch.sv
sprite_pixel_pipe.sv
sprite_blend.sv
sprite_engine.sv
tb_sprite_models.sv
tb_sprite_engine.sv

//--- run_sim.sh
#!/bin/sh
# build and run the sprite engine testbench with verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f compile.f --top-module tb_sprite_engine \
  --Mdir obj_dir -o sim_sprite
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

out=$(./obj_dir/sim_sprite)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -q "TESTBENCH PASSED"; then
  exit 0
fi
exit 1
